/* Bender.yml */
package:
  name: bf_core

sources:
  - design/DekatronPkg.sv
  - design/BfIsaPkg.sv
  - design/DekatronCounter.sv
  - design/ProgramStore.sv
  - design/IpLine.sv
  - design/DataTape.sv
  - design/Sequencer.sv
  - design/BfCore.sv
  - target: test
    files:
      - tb/BfCoreProps.sv
      - tb/BfCoreTb.sv

/* design/BfCore.sv */
`timescale 1ns/100ps

module BfCore #(
    parameter int IpDigits   = 3,
    parameter int LoopDigits = 2,
    parameter int TapeDepth  = 16,
    localparam int ProgAddrWidth = $clog2(10 ** IpDigits)
) (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Start,
    input  logic HaltRq,
    input  logic ProgWe,
    input  logic [ProgAddrWidth-1:0] ProgAddr,
    input  BfIsaPkg::opcode_t ProgData,
    output logic OutValid,
    output logic [BfIsaPkg::CellWidth-1:0] OutData,
    output logic Done
);

    logic ipRequest;
    logic ipReady;
    BfIsaPkg::opcode_t ipInsn;
    DekatronPkg::digit_t [IpDigits-1:0] address;
    logic progRequest;
    logic progReady;
    BfIsaPkg::opcode_t progInsn;
    BfIsaPkg::tapeCmd_t tapeCmd;
    logic cellZero;

    IpLine #(
        .IpDigits   (IpDigits),
        .LoopDigits (LoopDigits)
    ) ipLine (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .HaltRq       (HaltRq),
        .dataIsZeroed (cellZero),
        .Request      (ipRequest),
        .Ready        (ipReady),
        .Address      (address),
        .LoopCount    (),
        .Insn         (ipInsn),
        .ProgRequest  (progRequest),
        .ProgReady    (progReady),
        .ProgInsn     (progInsn)
    );

    ProgramStore #(.IpDigits(IpDigits)) programStore (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .Request  (progRequest),
        .Address  (address),
        .ProgWe   (ProgWe),
        .ProgAddr (ProgAddr),
        .ProgData (ProgData),
        .Ready    (progReady),
        .Insn     (progInsn)
    );

    DataTape #(.TapeDepth(TapeDepth)) dataTape (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .Cmd      (tapeCmd),
        .Zero     (cellZero),
        .OutValid (OutValid),
        .OutData  (OutData)
    );

    Sequencer sequencer (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .Start     (Start),
        .IpRequest (ipRequest),
        .IpReady   (ipReady),
        .IpInsn    (ipInsn),
        .Cmd       (tapeCmd),
        .Done      (Done)
    );

endmodule

/* design/BfIsaPkg.sv */
package BfIsaPkg;

    localparam int InsnWidth = 4;
    localparam int CellWidth = 8;

    typedef enum logic [InsnWidth-1:0] {
        OpNop       = 4'd0,
        OpInc       = 4'd1,
        OpDec       = 4'd2,
        OpRight     = 4'd3,
        OpLeft      = 4'd4,
        OpOut       = 4'd5,
        OpLoopOpen  = 4'd6,
        OpLoopClose = 4'd7,
        OpHalt      = 4'd8
    } opcode_t;

    typedef struct packed {
        logic    valid;
        opcode_t op;
    } tapeCmd_t;

    // Unknown characters decode as no-op
    function automatic opcode_t fromChar(input logic [7:0] c);
        case (c)
            "+": return OpInc;
            "-": return OpDec;
            ">": return OpRight;
            "<": return OpLeft;
            ".": return OpOut;
            "[": return OpLoopOpen;
            "]": return OpLoopClose;
            "!": return OpHalt;
            default: return OpNop;
        endcase
    endfunction

    function automatic logic [7:0] toChar(input opcode_t op);
        case (op)
            OpInc: return "+";
            OpDec: return "-";
            OpRight: return ">";
            OpLeft: return "<";
            OpOut: return ".";
            OpLoopOpen: return "[";
            OpLoopClose: return "]";
            OpHalt: return "!";
            default: return " ";
        endcase
    endfunction

    // Opcodes carried out by the tape
    function automatic logic isDataOp(input opcode_t op);
        return op inside {OpInc, OpDec, OpRight, OpLeft, OpOut};
    endfunction

endpackage

/* design/DataTape.sv */
`timescale 1ns/100ps

module DataTape #(
    parameter int TapeDepth = 16
) (
    input  logic Clk,
    input  logic Rst_n,
    input  BfIsaPkg::tapeCmd_t Cmd,
    output logic Zero,
    output logic OutValid,
    output logic [BfIsaPkg::CellWidth-1:0] OutData
);

    localparam int PtrDigits = DekatronPkg::digitsFor(TapeDepth - 1);
    localparam DekatronPkg::row_t HomeRow = DekatronPkg::fromBinary(0, PtrDigits);

    logic [BfIsaPkg::CellWidth-1:0] cells [TapeDepth];
    DekatronPkg::digit_t [PtrDigits-1:0] ptr;    // Data pointer on its own tubes
    DekatronPkg::row_t ptrRow;
    DekatronPkg::row_t nextRow;
    int ptrIdx;
    int nextIdx;
    logic [BfIsaPkg::CellWidth-1:0] cellNow;
    logic [BfIsaPkg::CellWidth-1:0] cellNext;

    always_comb begin
        ptrRow = '0;
        ptrRow[PtrDigits-1:0] = ptr;
        ptrIdx   = DekatronPkg::toBinary(ptrRow, PtrDigits);
        cellNow  = cells[ptrIdx];
        cellNext = cellNow;
        nextIdx  = ptrIdx;
        case (Cmd.op)
            BfIsaPkg::OpInc: cellNext = cellNow + 1'b1;    // Wraps modulo 256
            BfIsaPkg::OpDec: cellNext = cellNow - 1'b1;
            BfIsaPkg::OpRight: nextIdx = (ptrIdx + 1) % TapeDepth;
            BfIsaPkg::OpLeft: nextIdx = (ptrIdx + TapeDepth - 1) % TapeDepth;
            default: ;
        endcase
        nextRow = DekatronPkg::fromBinary(nextIdx, PtrDigits);
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < TapeDepth; i++)
                cells[i] <= '0;
            ptr      <= HomeRow[PtrDigits-1:0];
            Zero     <= 1'b1;
            OutValid <= 1'b0;
        end else begin
            OutValid <= 1'b0;
            if (Cmd.valid) begin
                cells[ptrIdx] <= cellNext;
                ptr           <= nextRow[PtrDigits-1:0];
                Zero          <= (nextIdx == ptrIdx) ? (cellNext == '0) : (cells[nextIdx] == '0);
                OutValid      <= (Cmd.op == BfIsaPkg::OpOut);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (Cmd.valid && Cmd.op == BfIsaPkg::OpOut)
            OutData <= cellNow;
    end

endmodule

/* design/DekatronCounter.sv */
`timescale 1ns/100ps

module DekatronCounter #(
    parameter int Digits = 3
) (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Request,
    input  logic Dec,
    output logic Ready,
    output logic Zero,
    output DekatronPkg::digit_t [Digits-1:0] Out
);

    localparam int IdxWidth = $clog2(Digits + 1);
    localparam int Top = DekatronPkg::DekatronWidth - 1;

    logic busy;
    logic carry;    // Carry or borrow waiting for the next tube
    logic decReg;
    logic [IdxWidth-1:0] carryIdx;

    // Move the glow one cathode up or down the ring
    function automatic DekatronPkg::digit_t rotate(
        input DekatronPkg::digit_t d,
        input logic down
    );
        return down ? {d[0], d[Top:1]} : {d[Top-1:0], d[Top]};
    endfunction

    function automatic logic wraps(input DekatronPkg::digit_t d, input logic down);
        return down ? d[0] : d[Top];
    endfunction

    assign Ready = ~busy;

    always_comb begin
        Zero = 1'b1;
        for (int i = 0; i < Digits; i++)
            Zero = Zero & Out[i][0];    // Every ring on cathode 0
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < Digits; i++)
                Out[i] <= DekatronPkg::digit_t'(1);
            busy     <= 1'b0;
            carry    <= 1'b0;
            decReg   <= 1'b0;
            carryIdx <= '0;
        end else if (Request && !busy) begin
            Out[0]   <= rotate(Out[0], Dec);
            decReg   <= Dec;
            busy     <= 1'b1;
            carry    <= wraps(Out[0], Dec) && (Digits > 1);
            carryIdx <= IdxWidth'(1);
        end else if (busy) begin
            if (carry) begin    // One tube per clock
                Out[carryIdx] <= rotate(Out[carryIdx], decReg);
                carry         <= wraps(Out[carryIdx], decReg) && (carryIdx < Digits - 1);
                carryIdx      <= carryIdx + 1'b1;
            end else begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* design/DekatronPkg.sv */
package DekatronPkg;

    localparam int DekatronWidth = 10;
    localparam int MaxDigits = 6;    // Widest row the conversions take

    typedef logic [DekatronWidth-1:0] digit_t;
    typedef digit_t [MaxDigits-1:0] row_t;

    // Cathode position of a one-hot digit
    function automatic int digitValue(input digit_t d);
        int v;
        v = 0;
        for (int k = 0; k < DekatronWidth; k++) begin
            if (d[k])
                v = k;
        end
        return v;
    endfunction

    function automatic int toBinary(input row_t row, input int digits);
        int value;
        value = 0;
        for (int i = MaxDigits - 1; i >= 0; i--) begin
            if (i < digits)
                value = value * 10 + digitValue(row[i]);
        end
        return value;
    endfunction

    function automatic row_t fromBinary(input int value, input int digits);
        row_t row;
        int rest;
        row = '0;
        rest = value;
        for (int i = 0; i < MaxDigits; i++) begin
            if (i < digits) begin
                row[i] = digit_t'(1) << (rest % 10);
                rest = rest / 10;
            end
        end
        return row;
    endfunction

    // Tubes needed to show every value up to maxValue
    function automatic int digitsFor(input int maxValue);
        int n;
        n = 1;
        for (int i = 1; i < MaxDigits; i++) begin
            if (maxValue >= 10 ** i)
                n = i + 1;
        end
        return n;
    endfunction

endpackage

/* design/IpLine.sv */
`timescale 1ns/100ps

module IpLine #(
    parameter int IpDigits   = 3,
    parameter int LoopDigits = 2
) (
    input  logic Clk,
    input  logic Rst_n,
    input  logic HaltRq,
    input  logic dataIsZeroed,
    input  logic Request,
    output logic Ready,
    output DekatronPkg::digit_t [IpDigits-1:0] Address,
    output DekatronPkg::digit_t [LoopDigits-1:0] LoopCount,
    output BfIsaPkg::opcode_t Insn,
    output logic ProgRequest,
    input  logic ProgReady,
    input  BfIsaPkg::opcode_t ProgInsn
);

    typedef enum logic [2:0] {
        StIdle      = 3'd0,
        StIpCount   = 3'd1,
        StRomRead   = 3'd2,
        StLoopCount = 3'd3,
        StReady     = 3'd4,
        StHalt      = 3'd7
    } ipState_t;

    ipState_t state;

    logic ipReq;
    logic ipDec;
    logic ipReady;
    logic loopReq;
    logic loopDec;
    logic loopReady;
    logic loopZero;
    logic scanBack;    // Scan started by a taken ']'
    logic takenBracket;
    logic progBracket;

    DekatronCounter #(.Digits(IpDigits)) ipCounter (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .Request (ipReq),
        .Dec     (ipDec),
        .Ready   (ipReady),
        .Zero    (),
        .Out     (Address)
    );

    DekatronCounter #(.Digits(LoopDigits)) loopCounter (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .Request (loopReq),
        .Dec     (loopDec),
        .Ready   (loopReady),
        .Zero    (loopZero),
        .Out     (LoopCount)
    );

    assign takenBracket = (Insn == BfIsaPkg::OpLoopOpen && dataIsZeroed) ||
                          (Insn == BfIsaPkg::OpLoopClose && !dataIsZeroed);
    assign progBracket  = (ProgInsn == BfIsaPkg::OpLoopOpen) ||
                          (ProgInsn == BfIsaPkg::OpLoopClose);

    // A halt request also holds Ready low so a new fetch is not lost
    assign Ready = (state == StIdle) & ~Request & ~HaltRq;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state       <= StIdle;
            Insn        <= BfIsaPkg::OpNop;
            ipReq       <= 1'b0;
            ipDec       <= 1'b0;
            loopReq     <= 1'b0;
            loopDec     <= 1'b0;
            ProgRequest <= 1'b0;
            scanBack    <= 1'b0;
        end else begin
            case (state)
                StIdle: begin
                    if (Request) begin
                        if (!ProgReady) begin    // First fetch reads address 0
                            ProgRequest <= 1'b1;
                            state       <= StRomRead;
                        end else if (takenBracket) begin
                            scanBack <= (Insn == BfIsaPkg::OpLoopClose);
                            loopDec  <= 1'b0;
                            loopReq  <= 1'b1;
                            state    <= StLoopCount;
                        end else begin
                            ipDec <= 1'b0;
                            ipReq <= 1'b1;
                            state <= StIpCount;
                        end
                    end else if (HaltRq) begin
                        state <= StHalt;
                    end
                end
                StIpCount: begin
                    ipReq <= 1'b0;
                    if (!ipReq && ipReady) begin
                        ProgRequest <= 1'b1;
                        state       <= StRomRead;
                    end
                end
                StRomRead: begin
                    ProgRequest <= 1'b0;
                    if (ProgReady) begin
                        if (loopZero) begin
                            state <= StReady;
                        end else if (progBracket) begin
                            // Bracket against the direction of travel closes a level
                            loopDec <= (scanBack && ProgInsn == BfIsaPkg::OpLoopOpen) ||
                                       (!scanBack && ProgInsn == BfIsaPkg::OpLoopClose);
                            loopReq <= 1'b1;
                            state   <= StLoopCount;
                        end else begin
                            ipDec <= scanBack;
                            ipReq <= 1'b1;
                            state <= StIpCount;
                        end
                    end
                end
                StLoopCount: begin
                    loopReq <= 1'b0;
                    if (!loopReq && loopReady) begin
                        ipDec <= scanBack & ~loopZero;    // Matched, so step past it
                        ipReq <= 1'b1;
                        state <= StIpCount;
                    end
                end
                StReady: begin
                    Insn <= ProgInsn;
                    if (!Request)
                        state <= StIdle;
                end
                StHalt: begin
                    if (!HaltRq)
                        state <= StIdle;
                end
                default: state <= StIdle;
            endcase
        end
    end

endmodule

/* design/ProgramStore.sv */
`timescale 1ns/100ps

module ProgramStore #(
    parameter int IpDigits = 3,
    localparam int AddrWidth = $clog2(10 ** IpDigits)
) (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Request,
    input  DekatronPkg::digit_t [IpDigits-1:0] Address,
    input  logic ProgWe,
    input  logic [AddrWidth-1:0] ProgAddr,
    input  BfIsaPkg::opcode_t ProgData,
    output logic Ready,
    output BfIsaPkg::opcode_t Insn
);

    localparam int Depth = 10 ** IpDigits;

    BfIsaPkg::opcode_t mem [Depth];
    DekatronPkg::row_t addrRow;
    logic readDone;

    always_comb begin
        addrRow = '0;
        addrRow[IpDigits-1:0] = Address;
    end

    assign Ready = readDone & ~Request;    // Low while a new read is asked for

    always_ff @(posedge Clk) begin
        if (ProgWe)
            mem[ProgAddr] <= ProgData;
        if (Request)
            Insn <= mem[DekatronPkg::toBinary(addrRow, IpDigits)];
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n)
            readDone <= 1'b0;
        else if (Request)
            readDone <= 1'b1;
    end

endmodule

/* design/Sequencer.sv */
`timescale 1ns/100ps

module Sequencer (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Start,
    output logic IpRequest,
    input  logic IpReady,
    input  BfIsaPkg::opcode_t IpInsn,
    output BfIsaPkg::tapeCmd_t Cmd,
    output logic Done
);

    typedef enum logic [2:0] {
        StWait,
        StFetch,
        StRelease,
        StDispatch,
        StFinished
    } seqState_t;

    seqState_t state;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state     <= StWait;
            IpRequest <= 1'b0;
            Cmd       <= '{valid: 1'b0, op: BfIsaPkg::OpNop};
            Done      <= 1'b0;
        end else begin
            case (state)
                StWait, StFinished: begin
                    if (Start) begin
                        Done  <= 1'b0;
                        state <= StFetch;
                    end
                end
                StFetch: begin
                    if (IpRequest) begin    // Request taken by the IP line
                        IpRequest <= 1'b0;
                        state     <= StRelease;
                    end else if (IpReady) begin
                        IpRequest <= 1'b1;
                    end
                end
                StRelease: begin
                    if (IpReady) begin
                        if (IpInsn == BfIsaPkg::OpHalt) begin
                            Done  <= 1'b1;
                            state <= StFinished;
                        end else begin
                            if (BfIsaPkg::isDataOp(IpInsn))
                                Cmd <= '{valid: 1'b1, op: IpInsn};
                            state <= StDispatch;
                        end
                    end
                end
                StDispatch: begin
                    if (Cmd.valid)
                        Cmd.valid <= 1'b0;    // Extra cycle lets Zero settle
                    else
                        state <= StFetch;
                end
                default: state <= StWait;
            endcase
        end
    end

endmodule

/* tb/BfCoreProps.sv */
`timescale 1ns/100ps

module BfCoreProps (
    input logic Clk,
    input logic Rst_n,
    input logic ipReq,
    input logic ipReady,
    input logic loopReq,
    input logic loopReady,
    input BfIsaPkg::tapeCmd_t cmd
);

    int failures = 0;

    // A counter only takes a request while it is at rest
    ipReqWhileReady: assert property (@(posedge Clk) disable iff (!Rst_n) ipReq |-> ipReady)
        else begin
            failures++;
            $error("Pointer counter requested while busy");
        end

    loopReqWhileReady: assert property (@(posedge Clk) disable iff (!Rst_n) loopReq |-> loopReady)
        else begin
            failures++;
            $error("Nesting counter requested while busy");
        end

    oneStrobePerDispatch: assert property (@(posedge Clk) disable iff (!Rst_n)
        cmd.valid |=> !cmd.valid)
        else begin
            failures++;
            $error("Tape command valid on two cycles in a row");
        end

    dataOpsOnly: assert property (@(posedge Clk) disable iff (!Rst_n)
        cmd.valid |-> cmd.op inside {BfIsaPkg::OpInc, BfIsaPkg::OpDec, BfIsaPkg::OpRight,
                                     BfIsaPkg::OpLeft, BfIsaPkg::OpOut})
        else begin
            failures++;
            $error("Tape command carries a non-data opcode");
        end

endmodule

/* tb/BfCoreTb.sv */
`timescale 1ns/100ps

module BfCoreTb;

    localparam int IpDigits      = 3;
    localparam int LoopDigits    = 2;
    localparam int TapeDepth     = 16;
    localparam int ProgAddrWidth = $clog2(10 ** IpDigits);
    localparam int NumProgs      = 6;
    localparam int CyclesPerStep = 200;
    localparam int MaxModelSteps = 100000;

    logic Clk = 1'b0;
    logic Rst_n;
    logic Start;
    logic HaltRq;
    logic ProgWe;
    logic [ProgAddrWidth-1:0] ProgAddr;
    BfIsaPkg::opcode_t ProgData;
    logic OutValid;
    logic [BfIsaPkg::CellWidth-1:0] OutData;
    logic Done;

    integer seed = 32'he572_5bde;
    byte unsigned prog[$];    // Program as characters
    logic [7:0] expQ[$];
    int modelSteps;
    int errors = 0;
    int checks = 0;
    int progsRun = 0;
    int gotCount;
    int expCount;
    int heldOuts = 0;    // Bytes seen during the current HaltRq hold
    logic started = 1'b0;
    logic timedOut = 1'b0;
    longint cycles = 0;
    longint cycleLimit = 200;

    BfCore #(
        .IpDigits   (IpDigits),
        .LoopDigits (LoopDigits),
        .TapeDepth  (TapeDepth)
    ) BfCore_inst (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .Start    (Start),
        .HaltRq   (HaltRq),
        .ProgWe   (ProgWe),
        .ProgAddr (ProgAddr),
        .ProgData (ProgData),
        .OutValid (OutValid),
        .OutData  (OutData),
        .Done     (Done)
    );

    bind IpLine BfCoreProps ipLineProps (
        .Clk(Clk), .Rst_n(Rst_n), .ipReq(ipReq), .ipReady(ipReady),
        .loopReq(loopReq), .loopReady(loopReady), .cmd('0)
    );
    bind DataTape BfCoreProps dataTapeProps (
        .Clk(Clk), .Rst_n(Rst_n), .ipReq(1'b0), .ipReady(1'b1),
        .loopReq(1'b0), .loopReady(1'b1), .cmd(Cmd)
    );

    always #50 Clk = ~Clk;

    function automatic int randRange(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic byte unsigned opcodeChar(input int idx);
        case (idx)
            0: return "+";
            1: return "-";
            2: return ">";
            3: return "<";
            default: return ".";
        endcase
    endfunction

    function automatic BfIsaPkg::opcode_t opOf(input byte unsigned c);
        case (c)
            "+": return BfIsaPkg::OpInc;
            "-": return BfIsaPkg::OpDec;
            ">": return BfIsaPkg::OpRight;
            "<": return BfIsaPkg::OpLeft;
            ".": return BfIsaPkg::OpOut;
            "[": return BfIsaPkg::OpLoopOpen;
            "]": return BfIsaPkg::OpLoopClose;
            "!": return BfIsaPkg::OpHalt;
            default: return BfIsaPkg::OpNop;
        endcase
    endfunction

    // Index of the bracket that pairs with the one at pos
    function automatic int matchOf(input int pos);
        int depth;
        int step;
        int i;
        depth = 0;
        step = (prog[pos] == "[") ? 1 : -1;
        i = pos;
        while (i >= 0 && i < prog.size()) begin
            if (prog[i] == "[")
                depth++;
            else if (prog[i] == "]")
                depth--;
            if (depth == 0)
                return i;
            i += step;
        end
        return prog.size();
    endfunction

    task automatic addRun(input int len);
        for (int i = 0; i < len; i++)
            prog.push_back(opcodeChar(randRange(0, 4)));
    endtask

    task automatic addText(input string s);
        for (int i = 0; i < s.len(); i++)
            prog.push_back(s[i]);
    endtask

    task automatic buildProgram;
        int pieces;
        pieces = randRange(8, 14);
        prog.delete();
        for (int i = 0; i < pieces; i++) begin
            case (randRange(0, 5))
                0, 1, 2: addRun(randRange(1, 6));
                3: addText("[-]");
                4: begin
                    addRun(randRange(1, 3));
                    addText("[->+<]>.");
                end
                default: begin    // The cleared cell skips the whole nested loop
                    addText("[-][.");
                    addRun(randRange(1, 4));
                    addText("[.");
                    addRun(randRange(0, 3));
                    addText("]]");
                end
            endcase
        end
        addText(".!");
    endtask

    task automatic runModel;
        logic [7:0] cells [TapeDepth];
        int pc;
        int ptr;
        for (int i = 0; i < TapeDepth; i++)
            cells[i] = 8'h00;
        expQ.delete();
        pc = 0;
        ptr = 0;
        modelSteps = 0;
        while (pc < prog.size() && prog[pc] != "!" && modelSteps < MaxModelSteps) begin
            modelSteps++;
            case (prog[pc])
                "+": cells[ptr] = cells[ptr] + 8'd1;
                "-": cells[ptr] = cells[ptr] - 8'd1;
                ">": ptr = (ptr + 1) % TapeDepth;
                "<": ptr = (ptr + TapeDepth - 1) % TapeDepth;
                ".": expQ.push_back(cells[ptr]);
                "[": if (cells[ptr] == 8'h00) pc = matchOf(pc);
                "]": if (cells[ptr] != 8'h00) pc = matchOf(pc);
                default: ;
            endcase
            pc++;
        end
        expCount = expQ.size();
    endtask

    task automatic applyReset;
        @(posedge Clk);
        Rst_n <= 1'b0;
        started = 1'b0;
        repeat (4) @(posedge Clk);
        Rst_n <= 1'b1;
    endtask

    task automatic loadProgram;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge Clk);
            ProgWe   <= 1'b1;
            ProgAddr <= ProgAddrWidth'(i);
            ProgData <= opOf(prog[i]);
        end
        @(posedge Clk);
        ProgWe <= 1'b0;
    endtask

    // Random HaltRq holds while the program runs
    task automatic waitDone;
        int holdLeft;
        holdLeft = 0;
        do begin
            @(posedge Clk);
            if (holdLeft > 0) begin
                holdLeft--;
                if (holdLeft == 0)
                    HaltRq <= 1'b0;
            end else if (randRange(0, 47) == 0) begin
                HaltRq <= 1'b1;
                holdLeft = randRange(4, 40);
            end
            @(negedge Clk);
        end while (!Done);
        @(posedge Clk);
        HaltRq <= 1'b0;
    endtask

    task automatic finishRun;
        int propFails;
        propFails = BfCore_inst.ipLine.ipLineProps.failures +
                    BfCore_inst.dataTape.dataTapeProps.failures;
        $display("Programs %0d, checks %0d, errors %0d, property failures %0d",
                 progsRun, checks, errors, propFails);
        if (errors == 0 && propFails == 0 && !timedOut)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge Clk) begin
        logic [7:0] expByte;
        if (!HaltRq)
            heldOuts = 0;
        else if (OutValid)
            heldOuts++;    // Only the instruction already under way may still print
        if (!started) begin
            checks++;
            assert (!OutValid && !Done) else begin
                errors++;
                $display("Output strobe or Done seen before Start");
            end
        end else if (OutValid) begin
            checks++;
            gotCount++;
            assert (!Done) else begin
                errors++;
                $display("Output strobe after Done");
            end
            assert (heldOuts <= 1) else begin
                errors++;
                $display("More than one output byte while HaltRq was held");
            end
            assert (expQ.size() > 0) else begin
                errors++;
                $display("More output bytes than the model produced");
            end
            if (expQ.size() > 0) begin
                expByte = expQ.pop_front();
                assert (OutData === expByte) else begin
                    errors++;
                    $display("FAIL OutData: expected %h, got %h", expByte, OutData);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles <= cycleLimit) begin
            @(posedge Clk);
            cycles++;
        end
        timedOut = 1'b1;
        $display("Timeout after %0d cycles, the machine never reached Done", cycles);
        finishRun();
    end

    initial begin : stimulus
        Rst_n    = 1'b0;
        Start    = 1'b0;
        HaltRq   = 1'b0;
        ProgWe   = 1'b0;
        ProgAddr = '0;
        ProgData = BfIsaPkg::OpNop;
        for (int p = 0; p < NumProgs; p++) begin
            applyReset();
            buildProgram();
            runModel();
            // Budget from executed steps, scan length and load time
            cycleLimit += longint'(modelSteps + prog.size()) * CyclesPerStep + 1000;
            loadProgram();
            repeat (randRange(2, 9)) @(posedge Clk);
            gotCount = 0;
            Start <= 1'b1;
            started = 1'b1;
            @(posedge Clk);
            Start <= 1'b0;
            waitDone();
            repeat (20) @(posedge Clk);    // Nothing more may come out
            checks++;
            assert (gotCount == expCount) else begin
                errors++;
                $display("FAIL OutValid count: expected %h, got %h", expCount, gotCount);
            end
            progsRun++;
        end
        finishRun();
    end

endmodule

/* verilog.f */
design/DekatronPkg.sv
design/BfIsaPkg.sv
design/DekatronCounter.sv
design/ProgramStore.sv
design/IpLine.sv
design/DataTape.sv
design/Sequencer.sv
design/BfCore.sv
tb/BfCoreProps.sv
tb/BfCoreTb.sv
